// ==== include/fifo_lab_macros.svh ====
`ifndef FIFO_LAB_MACROS_SVH
`define FIFO_LAB_MACROS_SVH

// ------------------------------
// FIFO geometry
// ------------------------------

// width of one stored value in bits
`define FIFO_WIDTH 4

// number of slots, one per display digit
`define FIFO_DEPTH 8

// ------------------------------
// seven-segment display
// ------------------------------

// digits on the board
`define W_DIGIT 8

// clock cycles each digit stays lit
`define DIGIT_PERIOD 16

`endif

// ==== source/fifo_lab_pkg.sv ====
`include "fifo_lab_macros.svh"

package fifo_lab_pkg;

    // ------------------------------
    // payload and pointer types
    // ------------------------------

    // one hex digit, the value carried by the FIFO
    typedef logic [`FIFO_WIDTH - 1:0] nibble_t;

    // slot index, three bits for eight slots
    typedef logic [$clog2(`FIFO_DEPTH) - 1:0] ptr_t;

    // ------------------------------
    // display types
    // ------------------------------

    // segments in abcdefgh order, bit 7 is a and bit 0 is the dot
    typedef logic [7:0] seg_t;

    // middle bar only, marks a slot with no live entry
    localparam seg_t SEG_EMPTY_ENTRY = 8'b0000_0010;

endpackage

// ==== source/nibble_source.sv ====
`timescale 1ns/1ps

module nibble_source
    import fifo_lab_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    output nibble_t write_data
);

    // one table entry per possible index value
    localparam int N_ENTRY = 16;
    localparam int W_INDEX = $clog2(N_ENTRY);

    // ------------------------------
    // value table
    // ------------------------------

    localparam nibble_t VALUES [N_ENTRY] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    logic [W_INDEX - 1:0] index;

    // ------------------------------
    // index counter
    // ------------------------------

    // moves only on accepted pushes, wraps after the last entry
    always_ff @(posedge clk)
    begin
        if (rst)
            index <= '0;
        else if (push)
            index <= index + 1'b1;
    end

    // value for the next push is ready before the edge that takes it
    assign write_data = VALUES[index];

endmodule

// ==== source/debug_fifo.sv ====
`timescale 1ns/1ps

`include "fifo_lab_macros.svh"

module debug_fifo
    import fifo_lab_pkg::*;
#(
    parameter type payload_t = nibble_t
)
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  logic                         pop,
    input  payload_t                     write_data,
    output payload_t                     read_data,
    output logic                         empty,
    output logic                         full,
    output ptr_t                         wr_ptr,
    output ptr_t                         rd_ptr,
    output logic [`FIFO_DEPTH - 1:0]     slot_valid,
    output payload_t [`FIFO_DEPTH - 1:0] slot_data
);

    localparam ptr_t LAST_SLOT = ptr_t'(`FIFO_DEPTH - 1);

    ptr_t                         wr_ptr_q;
    ptr_t                         rd_ptr_q;
    logic                         wr_wrap_q;
    logic                         rd_wrap_q;
    logic [`FIFO_DEPTH - 1:0]     valid_q;
    payload_t [`FIFO_DEPTH - 1:0] data_q;

    // ------------------------------
    // write side
    // ------------------------------

    // the wrap bit flips each time the pointer passes the last slot
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr_q  <= '0;
            wr_wrap_q <= 1'b0;
        end
        else if (push)
        begin
            if (wr_ptr_q == LAST_SLOT)
            begin
                wr_ptr_q  <= '0;
                wr_wrap_q <= ~wr_wrap_q;
            end
            else
            begin
                wr_ptr_q <= ptr_t'(wr_ptr_q + 1'b1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            data_q[wr_ptr_q] <= write_data;
    end

    // ------------------------------
    // read side
    // ------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_ptr_q  <= '0;
            rd_wrap_q <= 1'b0;
        end
        else if (pop)
        begin
            if (rd_ptr_q == LAST_SLOT)
            begin
                rd_ptr_q  <= '0;
                rd_wrap_q <= ~rd_wrap_q;
            end
            else
            begin
                rd_ptr_q <= ptr_t'(rd_ptr_q + 1'b1);
            end
        end
    end

    // ------------------------------
    // per-slot valid flags
    // ------------------------------

    // push and pop never touch the same slot in one cycle:
    // equal pointers mean either empty (pop blocked) or full (push blocked)
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else
        begin
            if (push)
                valid_q[wr_ptr_q] <= 1'b1;
            if (pop)
                valid_q[rd_ptr_q] <= 1'b0;
        end
    end

    // ------------------------------
    // status and debug view
    // ------------------------------

    // show-ahead head of queue
    assign read_data = data_q[rd_ptr_q];

    assign empty = (wr_ptr_q == rd_ptr_q) && (wr_wrap_q == rd_wrap_q);
    assign full  = (wr_ptr_q == rd_ptr_q) && (wr_wrap_q != rd_wrap_q);

    assign wr_ptr     = wr_ptr_q;
    assign rd_ptr     = rd_ptr_q;
    assign slot_valid = valid_q;
    assign slot_data  = data_q;

endmodule

// ==== source/fifo_display.sv ====
`timescale 1ns/1ps

`include "fifo_lab_macros.svh"

module fifo_display
    import fifo_lab_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`FIFO_DEPTH - 1:0]    slot_valid,
    input  nibble_t [`FIFO_DEPTH - 1:0] slot_data,
    input  ptr_t                        wr_ptr,
    input  ptr_t                        rd_ptr,
    output seg_t                        abcdefgh,
    output logic [`W_DIGIT - 1:0]       digit
);

    localparam int N_DIGIT = `W_DIGIT;
    localparam int N_SLOT  = `FIFO_DEPTH;
    localparam int W_SCAN  = $clog2(`DIGIT_PERIOD);
    localparam int W_POS   = $clog2(N_DIGIT);

    localparam ptr_t LAST_SLOT = ptr_t'(N_SLOT - 1);

    logic [W_SCAN - 1:0]  scan_cnt;
    logic                 scan_step;
    logic                 scan_on;
    logic [W_POS - 1:0]   scan_pos;
    ptr_t                 slot_sel;
    logic [N_DIGIT - 1:0] digit_next;
    seg_t                 seg_next;

    // hex digit to segments, dot left clear
    function automatic seg_t hex_to_seg(input nibble_t value);
        case (value)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    // ------------------------------
    // scan divider
    // ------------------------------

    assign scan_step = (scan_cnt == W_SCAN'(`DIGIT_PERIOD - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (scan_step)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    // ------------------------------
    // digit rotation
    // ------------------------------

    // left to right: start at the top bit, count down, wrap to the top again
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_on  <= 1'b0;
            scan_pos <= '0;
        end
        else if (scan_step)
        begin
            scan_on <= 1'b1;
            if (!scan_on || scan_pos == '0)
                scan_pos <= W_POS'(N_DIGIT - 1);
            else
                scan_pos <= scan_pos - 1'b1;
        end
    end

    // mirror: leftmost digit shows slot 0
    assign slot_sel   = LAST_SLOT - ptr_t'(scan_pos);
    assign digit_next = N_DIGIT'(1) << scan_pos;

    // ------------------------------
    // segment pattern
    // ------------------------------

    always_comb
    begin
        if (slot_valid[slot_sel])
            seg_next = hex_to_seg(slot_data[slot_sel]);
        else
            seg_next = SEG_EMPTY_ENTRY;

        // dot marks where either pointer sits
        if (slot_sel == wr_ptr || slot_sel == rd_ptr)
            seg_next[0] = 1'b1;
    end

    // digit and segments leave together, one cycle behind the select
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            digit    <= '0;
            abcdefgh <= '0;
        end
        else if (scan_on)
        begin
            digit    <= digit_next;
            abcdefgh <= seg_next;
        end
    end

endmodule

// ==== source/fifo_lab_top.sv ====
`timescale 1ns/1ps

`include "fifo_lab_macros.svh"

module fifo_lab_top
    import fifo_lab_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [1:0]            key,
    output seg_t                  abcdefgh,
    output logic [`W_DIGIT - 1:0] digit,
    output logic [7:0]            led
);

    logic                        push;
    logic                        pop;
    nibble_t                     write_data;
    nibble_t                     read_data;
    logic                        empty;
    logic                        full;
    ptr_t                        wr_ptr;
    ptr_t                        rd_ptr;
    logic [`FIFO_DEPTH - 1:0]    slot_valid;
    nibble_t [`FIFO_DEPTH - 1:0] slot_data;

    // ------------------------------
    // key gating
    // ------------------------------

    // blocked requests are simply dropped, nothing waits for them
    assign push = key[1] & ~full;
    assign pop  = key[0] & ~empty;

    // ------------------------------
    // producer, FIFO and display
    // ------------------------------

    nibble_source i_source
    (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .write_data (write_data)
    );

    debug_fifo #(.payload_t(nibble_t)) i_fifo
    (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .write_data (write_data),
        .read_data  (read_data),
        .empty      (empty),
        .full       (full),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .slot_valid (slot_valid),
        .slot_data  (slot_data)
    );

    fifo_display i_display
    (
        .clk        (clk),
        .rst        (rst),
        .slot_valid (slot_valid),
        .slot_data  (slot_data),
        .wr_ptr     (wr_ptr),
        .rd_ptr     (rd_ptr),
        .abcdefgh   (abcdefgh),
        .digit      (digit)
    );

    // status LEDs: empty, full, two unused, head value
    assign led = {empty, full, 2'b00, read_data};

endmodule

// ==== testbench/fifo_lab_assertions.sv ====
`timescale 1ns/1ps

`include "fifo_lab_macros.svh"

module fifo_lab_assertions
(
    input logic                     clk,
    input logic                     rst,
    input logic                     push,
    input logic                     pop,
    input logic                     empty,
    input logic                     full,
    input logic [`FIFO_DEPTH - 1:0] slot_valid
);

    int fail_count = 0;

    // ------------------------------
    // request gating seen by the FIFO
    // ------------------------------

    no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else
        begin
            $error("push request reached the FIFO while it was full");
            fail_count++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else
        begin
            $error("pop request reached the FIFO while it was empty");
            fail_count++;
        end

    // ------------------------------
    // status flags
    // ------------------------------

    // empty means no live slot and full means every slot is live
    flags_match_slots: assert property (@(posedge clk) disable iff (rst)
        (!empty || slot_valid == '0) && (!full || &slot_valid))
        else
        begin
            $error("empty or full disagrees with the slot valid flags");
            fail_count++;
        end

    // a reset cycle always leaves an empty FIFO behind
    empty_after_reset: assert property (@(posedge clk) rst |=> empty)
        else
        begin
            $error("FIFO is not empty after reset");
            fail_count++;
        end

endmodule

// ==== testbench/fifo_lab_tb.sv ====
`timescale 1ns/1ps

`include "fifo_lab_macros.svh"

module fifo_lab_tb
    import fifo_lab_pkg::*;
();

    localparam int SCAN_CYCLES = `W_DIGIT * `DIGIT_PERIOD;
    localparam int MAX_STEPS   = 32;

    // segment g alone
    localparam seg_t EMPTY_SIGN = 8'b0000_0010;

    localparam nibble_t VALUE_TABLE [16] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3
    };

    // abcdefgh patterns for 0 to F with the dot clear
    localparam seg_t HEX_SEG [16] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010,
        8'b0110_0110, 8'b1011_0110, 8'b1011_1110, 8'b1110_0000,
        8'b1111_1110, 8'b1111_0110, 8'b1110_1110, 8'b0011_1110,
        8'b1001_1100, 8'b0111_1010, 8'b1001_1110, 8'b1000_1110
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic [1:0]            key;
    seg_t                  abcdefgh;
    logic [`W_DIGIT - 1:0] digit;
    logic [7:0]            led;

    logic [7:0] stim [3 * MAX_STEPS];
    nibble_t    model_q [$];
    int         table_idx;
    int         model_wr;
    int         model_rd;
    int         error_count;
    int         timeout_count;

    always #5 clk = ~clk;

    fifo_lab_top i_dut
    (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .led      (led)
    );

    bind debug_fifo fifo_lab_assertions i_fifo_checks
    (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .empty      (empty),
        .full       (full),
        .slot_valid (slot_valid)
    );

    // ------------------------------
    // reference model
    // ------------------------------

    // requests blocked by full or empty leave the model untouched
    function automatic void model_push();
        if (model_q.size() < `FIFO_DEPTH)
        begin
            model_q.push_back(VALUE_TABLE[table_idx]);
            table_idx = (table_idx + 1) % 16;
            model_wr  = (model_wr + 1) % `FIFO_DEPTH;
        end
    endfunction

    function automatic void model_pop();
        if (model_q.size() > 0)
        begin
            void'(model_q.pop_front());
            model_rd = (model_rd + 1) % `FIFO_DEPTH;
        end
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    // hold one key for a number of cycles and step the model at each sampled edge
    task automatic hold_key(input int which, input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge clk);
            key[which] <= 1'b1;
            if (which == 1)
                model_push();
            else
                model_pop();
        end
        @(posedge clk);
        key[which] <= 1'b0;
    endtask

    // ------------------------------
    // display scan check
    // ------------------------------

    task automatic check_display(input string name);
        int                    slot;
        int                    offset;
        int                    waited;
        seg_t                  expected;
        logic [`W_DIGIT - 1:0] want_digit;
        for (int pos = `W_DIGIT - 1; pos >= 0; pos--)
        begin
            slot   = `FIFO_DEPTH - 1 - pos;
            offset = (slot - model_rd + `FIFO_DEPTH) % `FIFO_DEPTH;
            if (offset < model_q.size())
                expected = HEX_SEG[model_q[offset]];
            else
                expected = EMPTY_SIGN;
            if (slot == model_wr || slot == model_rd)
                expected[0] = 1'b1;
            want_digit      = '0;
            want_digit[pos] = 1'b1;
            waited = 0;
            @(negedge clk);
            while (digit !== want_digit && waited < 2 * SCAN_CYCLES)
            begin
                @(negedge clk);
                waited++;
            end
            if (digit !== want_digit)
            begin
                $display("%s: digit %0d was never lit during the scan", name, pos);
                timeout_count++;
            end
            else
            begin
                check_value($sformatf("%s slot %0d", name, slot), int'(expected),
                            int'(abcdefgh));
            end
        end
    endtask

    task automatic check_leds(input string name);
        @(negedge clk);
        check_value({name, " empty"}, int'(model_q.size() == 0), int'(led[7]));
        check_value({name, " full"}, int'(model_q.size() == `FIFO_DEPTH), int'(led[6]));
        check_value({name, " spare"}, 0, int'(led[5:4]));
        if (model_q.size() > 0)
            check_value({name, " head"}, int'(model_q[0]), int'(led[3:0]));
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial
    begin
        string name;
        int    n_push;
        int    n_pop;
        int    assert_fails;
        void'($urandom(32'h6601_8eb3));
        key           = 2'b00;
        rst           = 1'b1;
        table_idx     = 0;
        model_wr      = 0;
        model_rd      = 0;
        error_count   = 0;
        timeout_count = 0;
        for (int i = 0; i < 3 * MAX_STEPS; i++)
            stim[i] = 8'hff;
        $readmemh("testbench/fifo_lab_stimulus.txt", stim);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (SCAN_CYCLES + 1) @(posedge clk);
        check_leds("reset");
        check_display("reset");

        for (int step = 0; step < MAX_STEPS; step++)
        begin
            if (stim[3 * step] == 8'hff)
                break;
            name   = $sformatf("step %0d", step);
            n_push = int'(stim[3 * step]);
            n_pop  = int'(stim[3 * step + 1]);
            hold_key(1, n_push);
            repeat ($urandom_range(3, 0)) @(posedge clk);
            hold_key(0, n_pop);
            repeat (SCAN_CYCLES + 1) @(posedge clk);
            check_leds(name);
            if (model_q.size() > 0)
                check_value({name, " table head"}, int'(stim[3 * step + 2]),
                            int'(led[3:0]));
            check_display(name);
        end

        assert_fails = i_dut.i_fifo.i_fifo_checks.fail_count;
        $display("check errors: %0d, timeouts: %0d, assertion failures: %0d",
                 error_count, timeout_count, assert_fails);
        if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/fifo_lab_pkg.sv
source/nibble_source.sv
source/debug_fifo.sv
source/fifo_display.sv
source/fifo_lab_top.sv
testbench/fifo_lab_assertions.sv
testbench/fifo_lab_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module fifo_lab_tb -o fifo_lab_sim
	./obj_dir/fifo_lab_sim | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/fifo_lab_stimulus.txt ====
// columns: push count, pop count, expected head after the step (all hex)
// head is 00 and unchecked when the step leaves the FIFO empty, a line of ff ends the list
03 00 02
00 01 06
02 02 0b
0a 00 0b
00 03 0c
00 05 00
00 02 00
01 00 0a
04 01 0f
04 02 08
05 00 08
00 07 0e
03 02 04
00 02 00
ff ff ff
